/* mipsPipeline.f */
+incdir+verif
logic/isaPkg.sv
logic/pipelinePkg.sv
logic/fetchStage.sv
logic/hazardUnit.sv
logic/registerFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/mipsPipeline.sv
verif/mipsPipelineTb.sv

/* verif/programTable.svh */
// --------------------------------------------------
// test programs with expected retire and store streams
localparam int testCount = 6;
localparam int maxWords  = 12;
localparam int maxEvents = 8;

string                   testName      [testCount];
logic [dataWidth-1:0]    programWords  [testCount][maxWords];
int                      programLength [testCount];
logic [regAddrWidth-1:0] retireRegs    [testCount][maxEvents];
logic [dataWidth-1:0]    retireValues  [testCount][maxEvents];
int                      retireCount   [testCount];
logic [dataWidth-1:0]    storeAddrs    [testCount][maxEvents];
logic [dataWidth-1:0]    storeValues   [testCount][maxEvents];
int                      storeCount    [testCount];
int                      tableIndex;   // entry being filled

function automatic logic [dataWidth-1:0] aluWord(input functT funct, input int rd, input int rs,
                                                 input int rt);
   return {rType, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
endfunction

function automatic logic [dataWidth-1:0] shiftWord(input int rd, input int rt, input int shamt);
   return {rType, 5'd0, rt[4:0], rd[4:0], shamt[4:0], sllF};
endfunction

// lw/sw: rt, imm(rs)   beq: rs, rt, word offset
function automatic logic [dataWidth-1:0] immWord(input opcodeT op, input int rs, input int rt,
                                                 input int imm);
   return {op, rs[4:0], rt[4:0], imm[15:0]};
endfunction

task automatic newTest(input string name);
   tableIndex++;
   testName[tableIndex]      = name;
   programLength[tableIndex] = 0;
   retireCount[tableIndex]   = 0;
   storeCount[tableIndex]    = 0;
endtask

task automatic addWord(input logic [dataWidth-1:0] word);
   programWords[tableIndex][programLength[tableIndex]] = word;
   programLength[tableIndex]++;
endtask

task automatic expectRetire(input int register, input int value);
   retireRegs[tableIndex][retireCount[tableIndex]]   = register[regAddrWidth-1:0];
   retireValues[tableIndex][retireCount[tableIndex]] = value;
   retireCount[tableIndex]++;
endtask

task automatic expectStore(input int address, input int value);
   storeAddrs[tableIndex][storeCount[tableIndex]]  = address;
   storeValues[tableIndex][storeCount[tableIndex]] = value;
   storeCount[tableIndex]++;
endtask

// memory word i holds i after reset, registers start at zero
task automatic buildTable();
   tableIndex = -1;

   newTest("alu operations");
   addWord(immWord(lw, 0, 1, 20));        // $1 = 5
   addWord(immWord(lw, 0, 2, 12));        // $2 = 3
   addWord(aluWord(addF, 3, 1, 2));
   addWord(aluWord(subF, 4, 1, 2));
   addWord(aluWord(andF, 5, 1, 2));
   addWord(aluWord(orF, 6, 1, 2));
   addWord(shiftWord(7, 1, 3));
   expectRetire(1, 5);
   expectRetire(2, 3);
   expectRetire(3, 8);
   expectRetire(4, 2);
   expectRetire(5, 1);
   expectRetire(6, 7);
   expectRetire(7, 40);

   newTest("forwarding chain");
   addWord(immWord(lw, 0, 1, 28));        // $1 = 7
   addWord(immWord(lw, 0, 2, 8));         // $2 = 2
   addWord(aluWord(addF, 3, 1, 2));
   addWord(aluWord(subF, 4, 3, 2));       // chain of three starts here
   addWord(aluWord(addF, 5, 4, 3));
   addWord(aluWord(orF, 6, 5, 4));
   expectRetire(1, 7);
   expectRetire(2, 2);
   expectRetire(3, 9);
   expectRetire(4, 7);
   expectRetire(5, 16);
   expectRetire(6, 23);

   newTest("load use");
   addWord(immWord(lw, 0, 3, 24));        // addend 6
   addWord(immWord(lw, 0, 1, 40));
   addWord(aluWord(addF, 2, 3, 1));       // uses $1 right away
   addWord(aluWord(subF, 4, 2, 1));
   expectRetire(3, 6);
   expectRetire(1, 10);
   expectRetire(2, 16);
   expectRetire(4, 6);

   newTest("store then load");
   addWord(immWord(lw, 0, 1, 12));
   addWord(immWord(lw, 0, 5, 4));
   addWord(aluWord(addF, 2, 1, 1));
   addWord(immWord(sw, 0, 2, 32));
   addWord(immWord(lw, 0, 3, 32));        // reads back the stored word
   addWord(aluWord(subF, 4, 5, 3));
   addWord(immWord(sw, 0, 4, 40));
   expectRetire(1, 3);
   expectRetire(5, 1);
   expectRetire(2, 6);
   expectRetire(3, 6);
   expectRetire(4, -5);
   expectStore(32, 6);
   expectStore(40, -5);

   newTest("branches");
   addWord(immWord(lw, 0, 1, 4));         // $1 = 1
   addWord(immWord(lw, 0, 2, 8));         // $2 = 2
   addWord(aluWord(addF, 3, 1, 1));
   addWord(immWord(beq, 3, 2, 1));        // taken, needs the add
   addWord(aluWord(addF, 4, 1, 1));       // skipped
   addWord(immWord(beq, 1, 2, 1));        // not taken
   addWord(aluWord(orF, 5, 1, 2));
   addWord(immWord(beq, 0, 0, 1));
   addWord(aluWord(addF, 6, 1, 1));       // skipped
   addWord(aluWord(subF, 7, 2, 1));
   expectRetire(1, 1);
   expectRetire(2, 2);
   expectRetire(3, 2);
   expectRetire(5, 3);
   expectRetire(7, 1);

   newTest("register zero");
   addWord(immWord(lw, 0, 0, 12));
   addWord(immWord(lw, 0, 1, 20));
   addWord(aluWord(addF, 0, 0, 1));
   addWord(aluWord(addF, 2, 0, 1));
   addWord(aluWord(orF, 3, 0, 0));
   expectRetire(1, 5);
   expectRetire(2, 5);
   expectRetire(3, 0);
endtask

/* verif/mipsPipelineTb.sv */
`timescale 1ns/1ps

module mipsPipelineTb
   import isaPkg::*;
();

   localparam int drainCycles = 8;   // pipeline depth plus worst stall

   logic                    clock;
   logic                    reset;
   logic [dataWidth-1:0]    instruction;
   logic [dataWidth-1:0]    fetchAddress;
   logic                    retireValid;
   logic [regAddrWidth-1:0] retireRegister;
   logic [dataWidth-1:0]    retireData;
   logic                    storeValid;
   logic [dataWidth-1:0]    storeAddress;
   logic [dataWidth-1:0]    storeData;

   int errorCount;
   int passCount;
   int cycleCount;
   int cycleLimit;

   `include "programTable.svh"

   mipsPipeline UUT (.*);

   always #4 clock = ~clock;   // 8 ns period

   // instruction memory model, nop past the end
   function automatic logic [dataWidth-1:0] fetchWord(input int t,
                                                      input logic [dataWidth-1:0] address);
      int index;
      index = int'(address >> 2);
      if (index < programLength[t])
         return programWords[t][index];
      return nopWord;
   endfunction

   // --------------------------------------------------
   // compare tasks
   task automatic retireCheck(input logic [regAddrWidth-1:0] gotReg,
                              input logic [dataWidth-1:0] gotData,
                              input logic [regAddrWidth-1:0] wantReg,
                              input logic [dataWidth-1:0] wantData);
      if (gotReg !== wantReg)
      begin
         $display("Mismatch at %0t ns: retireRegister got %0d, expected %0d",
                  $time, gotReg, wantReg);
         errorCount++;
      end
      if (gotData !== wantData)
      begin
         $display("Mismatch at %0t ns: retireData got %h, expected %h",
                  $time, gotData, wantData);
         errorCount++;
      end
   endtask

   task automatic storeCheck(input logic [dataWidth-1:0] gotAddr,
                             input logic [dataWidth-1:0] gotData,
                             input logic [dataWidth-1:0] wantAddr,
                             input logic [dataWidth-1:0] wantData);
      if (gotAddr !== wantAddr)
      begin
         $display("Mismatch at %0t ns: storeAddress got %h, expected %h",
                  $time, gotAddr, wantAddr);
         errorCount++;
      end
      if (gotData !== wantData)
      begin
         $display("Mismatch at %0t ns: storeData got %h, expected %h",
                  $time, gotData, wantData);
         errorCount++;
      end
   endtask

   // --------------------------------------------------
   // one table entry: reset, run until drained, check events
   task automatic runTest(input int t);
      int retireSeen;
      int storeSeen;
      int drain;
      int errorsBefore;
      retireSeen   = 0;
      storeSeen    = 0;
      drain        = 0;
      errorsBefore = errorCount;
      @(negedge clock);
      reset       = 1'b1;
      instruction = nopWord;
      repeat (4) @(negedge clock);
      reset = 1'b0;
      while (drain < drainCycles)
      begin
         instruction = fetchWord(t, fetchAddress);
         @(negedge clock);
         if (retireValid)
         begin
            if (retireSeen < retireCount[t])
               retireCheck(retireRegister, retireData,
                           retireRegs[t][retireSeen], retireValues[t][retireSeen]);
            else
            begin
               $display("at %0t ns an extra write of %h to register %0d was retired",
                        $time, retireData, retireRegister);
               errorCount++;
            end
            retireSeen++;
         end
         if (storeValid)
         begin
            if (storeSeen < storeCount[t])
               storeCheck(storeAddress, storeData,
                          storeAddrs[t][storeSeen], storeValues[t][storeSeen]);
            else
            begin
               $display("at %0t ns an extra store of %h to address %h was seen",
                        $time, storeData, storeAddress);
               errorCount++;
            end
            storeSeen++;
         end
         if (int'(fetchAddress >> 2) >= programLength[t])
            drain++;
      end
      if (retireSeen < retireCount[t])
      begin
         $display("only %0d of %0d register writes were retired", retireSeen, retireCount[t]);
         errorCount++;
      end
      if (storeSeen < storeCount[t])
      begin
         $display("only %0d of %0d stores were seen", storeSeen, storeCount[t]);
         errorCount++;
      end
      if (errorCount == errorsBefore)
      begin
         passCount++;
         $display("test %0d (%s): ok, %0d retires, %0d stores",
                  t, testName[t], retireSeen, storeSeen);
      end
      else
         $display("test %0d (%s): FAILED with %0d errors", t, testName[t],
                  errorCount - errorsBefore);
   endtask

   initial
   begin
      clock       = 1'b0;
      reset       = 1'b1;
      instruction = nopWord;
      errorCount  = 0;
      passCount   = 0;
      buildTable();
      cycleLimit = 0;
      for (int t = 0; t < testCount; t++)
         cycleLimit += 4 * programLength[t] + 20;
      for (int t = 0; t < testCount; t++)
         runTest(t);
      $display("%0d tests, %0d passed, %0d failed, %0d errors",
               testCount, passCount, testCount - passCount, errorCount);
      if (errorCount == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   // cycle counter guards against a hung pipeline
   initial
   begin
      cycleCount = 0;
      @(posedge clock);
      while (cycleCount < cycleLimit)
      begin
         cycleCount++;
         @(posedge clock);
      end
      $display("run stopped after the cycle limit of %0d was reached", cycleLimit);
      $display("Regression failed");
      $finish;
   end

endmodule

/* logic/mipsPipeline.sv */
`timescale 1ns/1ps

module mipsPipeline import isaPkg::*, pipelinePkg::*;
(
   input  logic                    clock,
   input  logic                    reset,
   input  logic [dataWidth-1:0]    instruction,
   output logic [dataWidth-1:0]    fetchAddress,
   output logic                    retireValid,
   output logic [regAddrWidth-1:0] retireRegister,
   output logic [dataWidth-1:0]    retireData,
   output logic                    storeValid,
   output logic [dataWidth-1:0]    storeAddress,
   output logic [dataWidth-1:0]    storeData
);

   // hazard and branch
   logic                    stall;
   logic                    flush;
   logic                    branchTaken;
   logic [dataWidth-1:0]    branchTarget;
   // IF/ID and register file
   logic [dataWidth-1:0]    idInstruction;
   logic [dataWidth-1:0]    idPcPlus4;
   logic [regAddrWidth-1:0] readAddrA;
   logic [regAddrWidth-1:0] readAddrB;
   logic [dataWidth-1:0]    readDataA;
   logic [dataWidth-1:0]    readDataB;
   // ID/EX
   logic                    exMemRead;
   logic                    exRegWrite;
   logic                    exMemToReg;
   logic                    exMemWrite;
   logic                    exAluSrc;
   aluClassT                exAluClass;
   logic [regAddrWidth-1:0] exRs;
   logic [regAddrWidth-1:0] exRt;
   logic [regAddrWidth-1:0] exDest;
   logic [dataWidth-1:0]    exDataA;
   logic [dataWidth-1:0]    exDataB;
   logic [dataWidth-1:0]    exImmediate;
   // EX/MEM
   logic                    memRegWrite;
   logic                    memMemRead;
   logic                    memMemWrite;
   logic                    memMemToReg;
   logic [regAddrWidth-1:0] memDest;
   logic [dataWidth-1:0]    memAluResult;
   logic [dataWidth-1:0]    memStoreData;
   // MEM/WB
   logic                    wbWrite;
   logic [regAddrWidth-1:0] wbDest;
   logic [dataWidth-1:0]    wbData;

   fetchStage   fetch   (.*);
   hazardUnit   hazard  (.*);
   decodeStage  decode  (.*);
   executeStage execute (.*);
   memoryStage  memory  (.*);

   registerFile regs
   (
      .clock       (clock),
      .reset       (reset),
      .readAddrA   (readAddrA),
      .readAddrB   (readAddrB),
      .writeEnable (wbWrite),
      .writeAddr   (wbDest),
      .writeData   (wbData),
      .readDataA   (readDataA),
      .readDataB   (readDataB)
   );

   // every register write retires
   assign retireValid    = wbWrite;
   assign retireRegister = wbDest;
   assign retireData     = wbData;

endmodule

/* logic/memoryStage.sv */
`timescale 1ns/1ps

module memoryStage import isaPkg::*, pipelinePkg::*;
(
   input  logic                    clock,
   input  logic                    reset,
   input  logic                    memRegWrite,
   input  logic                    memMemRead,
   input  logic                    memMemWrite,
   input  logic                    memMemToReg,
   input  logic [regAddrWidth-1:0] memDest,
   input  logic [dataWidth-1:0]    memAluResult,
   input  logic [dataWidth-1:0]    memStoreData,
   output logic                    wbWrite,
   output logic [regAddrWidth-1:0] wbDest,
   output logic [dataWidth-1:0]    wbData,
   output logic                    storeValid,
   output logic [dataWidth-1:0]    storeAddress,
   output logic [dataWidth-1:0]    storeData
);

   logic [dataWidth-1:0]     dataMemory [dataDepth];
   logic [dataAddrWidth-1:0] wordAddress;
   logic [dataWidth-1:0]     loadData;

   assign wordAddress = memAluResult[dataAddrWidth+1:2];   // byte to word address
   assign loadData    = memMemRead ? dataMemory[wordAddress] : '0;

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         for (int i = 0; i < dataDepth; i++)
            dataMemory[i] <= dataWidth'(i);   // word i holds i
      end
      else if (memMemWrite)
         dataMemory[wordAddress] <= memStoreData;
   end

   assign storeValid   = memMemWrite;
   assign storeAddress = memAluResult;
   assign storeData    = memStoreData;

   // --------------------------------------------------
   // MEM/WB
   always_ff @(posedge clock)
   begin
      if (reset)
         wbWrite <= 1'b0;
      else
         wbWrite <= memRegWrite && (memDest != '0);   // no retire for $0
   end

   always_ff @(posedge clock)
   begin
      wbDest <= memDest;
      wbData <= memMemToReg ? loadData : memAluResult;
   end

endmodule

/* logic/executeStage.sv */
`timescale 1ns/1ps

module executeStage import isaPkg::*, pipelinePkg::*;
(
   input  logic                    clock,
   input  logic                    reset,
   input  logic                    exMemRead,
   input  logic                    exRegWrite,
   input  logic                    exMemToReg,
   input  logic                    exMemWrite,
   input  logic                    exAluSrc,
   input  aluClassT                exAluClass,
   input  logic [regAddrWidth-1:0] exRs,
   input  logic [regAddrWidth-1:0] exRt,
   input  logic [regAddrWidth-1:0] exDest,
   input  logic [dataWidth-1:0]    exDataA,
   input  logic [dataWidth-1:0]    exDataB,
   input  logic [dataWidth-1:0]    exImmediate,
   input  logic                    wbWrite,
   input  logic [regAddrWidth-1:0] wbDest,
   input  logic [dataWidth-1:0]    wbData,
   output logic                    memRegWrite,
   output logic                    memMemRead,
   output logic                    memMemWrite,
   output logic                    memMemToReg,
   output logic [regAddrWidth-1:0] memDest,
   output logic [dataWidth-1:0]    memAluResult,
   output logic [dataWidth-1:0]    memStoreData
);

   forwardT                    forwardA;
   forwardT                    forwardB;
   logic [dataWidth-1:0]       operandA;
   logic [dataWidth-1:0]       storeValue;   // forwarded rt and sw data
   logic [dataWidth-1:0]       operandB;
   functT                      funct;
   logic [shamtMsb-shamtLsb:0] shamt;
   aluOpT                      aluOp;
   logic [dataWidth-1:0]       aluResult;

   // newest producer wins
   function automatic forwardT pickSource(input logic [regAddrWidth-1:0] source);
      if (source == '0)
         return fromRegister;
      else if (memRegWrite && (memDest == source))
         return fromMemory;
      else if (wbWrite && (wbDest == source))
         return fromWriteBack;
      return fromRegister;
   endfunction

   function automatic logic [dataWidth-1:0] pickOperand(input forwardT sel,
                                                        input logic [dataWidth-1:0] regValue);
      case (sel)
         fromMemory:    return memAluResult;
         fromWriteBack: return wbData;
         default:       return regValue;
      endcase
   endfunction

   always_comb
   begin
      forwardA   = pickSource(exRs);
      forwardB   = pickSource(exRt);
      operandA   = pickOperand(forwardA, exDataA);
      storeValue = pickOperand(forwardB, exDataB);
   end

   assign operandB = exAluSrc ? exImmediate : storeValue;
   assign funct    = functT'(exImmediate[functMsb:functLsb]);
   assign shamt    = exImmediate[shamtMsb:shamtLsb];

   // --------------------------------------------------
   // ALU control and ALU
   always_comb
   begin
      case (exAluClass)
         memAccess: aluOp = aluAdd;   // base plus offset
         branchCmp: aluOp = aluSub;
         default:
         begin
            case (funct)
               subF:    aluOp = aluSub;
               andF:    aluOp = aluAnd;
               orF:     aluOp = aluOr;
               sllF:    aluOp = aluSll;
               default: aluOp = aluAdd;
            endcase
         end
      endcase
   end

   always_comb
   begin
      case (aluOp)
         aluSub:  aluResult = operandA - operandB;
         aluAnd:  aluResult = operandA & operandB;
         aluOr:   aluResult = operandA | operandB;
         aluSll:  aluResult = operandB << shamt;   // shifts rt
         default: aluResult = operandA + operandB;
      endcase
   end

   // EX/MEM
   always_ff @(posedge clock)
   begin
      if (reset)
         {memRegWrite, memMemRead, memMemWrite, memMemToReg} <= '0;
      else
         {memRegWrite, memMemRead, memMemWrite, memMemToReg} <=
            {exRegWrite, exMemRead, exMemWrite, exMemToReg};
   end

   always_ff @(posedge clock)
   begin
      memDest      <= exDest;
      memAluResult <= aluResult;
      memStoreData <= storeValue;
   end

   // load-use stall must keep a load address from being forwarded as data
   noLoadForward: assert property (@(posedge clock) disable iff (reset)
      (memMemRead && (exRegWrite || exMemWrite)) |-> (forwardA != fromMemory));

endmodule

/* logic/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage import isaPkg::*, pipelinePkg::*;
(
   input  logic                    clock,
   input  logic                    reset,
   input  logic [dataWidth-1:0]    idInstruction,
   input  logic [dataWidth-1:0]    idPcPlus4,
   input  logic                    stall,
   input  logic [dataWidth-1:0]    readDataA,
   input  logic [dataWidth-1:0]    readDataB,
   input  logic                    memRegWrite,
   input  logic [regAddrWidth-1:0] memDest,
   input  logic [dataWidth-1:0]    memAluResult,
   output logic [regAddrWidth-1:0] readAddrA,
   output logic [regAddrWidth-1:0] readAddrB,
   output logic                    branchTaken,
   output logic [dataWidth-1:0]    branchTarget,
   output logic                    exMemRead,
   output logic                    exRegWrite,
   output logic                    exMemToReg,
   output logic                    exMemWrite,
   output logic                    exAluSrc,
   output aluClassT                exAluClass,
   output logic [regAddrWidth-1:0] exRs,
   output logic [regAddrWidth-1:0] exRt,
   output logic [regAddrWidth-1:0] exDest,
   output logic [dataWidth-1:0]    exDataA,
   output logic [dataWidth-1:0]    exDataB,
   output logic [dataWidth-1:0]    exImmediate
);

   opcodeT                  opcode;
   logic [regAddrWidth-1:0] rs;
   logic [regAddrWidth-1:0] rt;
   logic [regAddrWidth-1:0] rd;
   logic [dataWidth-1:0]    immediate;
   logic [dataWidth-1:0]    compareA;
   logic [dataWidth-1:0]    compareB;
   logic                    regDst;
   logic                    aluSrc;
   logic                    memToReg;
   logic                    regWrite;
   logic                    memRead;
   logic                    memWrite;
   logic                    isBranch;
   aluClassT                aluClass;

   assign opcode    = opcodeT'(idInstruction[opcodeMsb:opcodeLsb]);
   assign rs        = idInstruction[rsMsb:rsLsb];
   assign rt        = idInstruction[rtMsb:rtLsb];
   assign rd        = idInstruction[rdMsb:rdLsb];
   assign immediate = {{(dataWidth - immMsb - 1){idInstruction[immMsb]}},
                       idInstruction[immMsb:immLsb]};
   assign readAddrA = rs;
   assign readAddrB = rt;

   // --------------------------------------------------
   // main control
   always_comb
   begin
      {regDst, aluSrc, memToReg, regWrite, memRead, memWrite, isBranch} = '0;
      aluClass = memAccess;
      case (opcode)
         rType:
         begin
            regDst   = 1'b1;
            regWrite = 1'b1;
            aluClass = rTypeFn;
         end
         lw:
         begin
            aluSrc   = 1'b1;
            memToReg = 1'b1;
            regWrite = 1'b1;
            memRead  = 1'b1;
         end
         sw:
         begin
            aluSrc   = 1'b1;
            memWrite = 1'b1;
         end
         beq:
         begin
            isBranch = 1'b1;
            aluClass = branchCmp;
         end
         default: ;   // unknown opcode runs as a bubble
      endcase
   end

   // --------------------------------------------------
   // branch compare, mem-stage ALU result forwarded in
   assign compareA = (memRegWrite && (memDest != '0) && (memDest == rs)) ? memAluResult : readDataA;
   assign compareB = (memRegWrite && (memDest != '0) && (memDest == rt)) ? memAluResult : readDataB;

   assign branchTaken  = isBranch && (compareA == compareB) && !stall;
   assign branchTarget = idPcPlus4 + {immediate[dataWidth-3:0], 2'b00};

   // ID/EX control, bubble while stalled
   always_ff @(posedge clock)
   begin
      if (reset || stall)
      begin
         {exMemRead, exRegWrite, exMemToReg, exMemWrite, exAluSrc} <= '0;
         exAluClass <= memAccess;
      end
      else
      begin
         {exMemRead, exRegWrite, exMemToReg, exMemWrite, exAluSrc} <=
            {memRead, regWrite, memToReg, memWrite, aluSrc};
         exAluClass <= aluClass;
      end
   end

   always_ff @(posedge clock)
   begin
      exRs        <= rs;
      exRt        <= rt;
      exDest      <= regDst ? rd : rt;   // rd for R-type, rt for lw
      exDataA     <= readDataA;
      exDataB     <= readDataB;
      exImmediate <= immediate;          // funct and shamt ride along here
   end

endmodule

/* logic/registerFile.sv */
`timescale 1ns/1ps

module registerFile import isaPkg::*;
(
   input  logic                    clock,
   input  logic                    reset,
   input  logic [regAddrWidth-1:0] readAddrA,
   input  logic [regAddrWidth-1:0] readAddrB,
   input  logic                    writeEnable,
   input  logic [regAddrWidth-1:0] writeAddr,
   input  logic [dataWidth-1:0]    writeData,
   output logic [dataWidth-1:0]    readDataA,
   output logic [dataWidth-1:0]    readDataB
);

   logic [dataWidth-1:0] registers [2**regAddrWidth];

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         for (int i = 0; i < 2**regAddrWidth; i++)
            registers[i] <= '0;
      end
      else if (writeEnable && (writeAddr != '0))   // $0 stays zero
         registers[writeAddr] <= writeData;
   end

   // write-back data passes straight to the reads
   assign readDataA = (writeEnable && (writeAddr == readAddrA) && (readAddrA != '0)) ?
                      writeData : registers[readAddrA];
   assign readDataB = (writeEnable && (writeAddr == readAddrB) && (readAddrB != '0)) ?
                      writeData : registers[readAddrB];

   // memory stage already drops $0 writes
   noZeroWrite: assert property (@(posedge clock) disable iff (reset)
      writeEnable |-> (writeAddr != '0));

endmodule

/* logic/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit import isaPkg::*;
(
   input  logic [dataWidth-1:0]    idInstruction,
   input  logic                    exMemRead,
   input  logic                    exRegWrite,
   input  logic [regAddrWidth-1:0] exDest,
   input  logic                    memMemRead,
   input  logic [regAddrWidth-1:0] memDest,
   input  logic                    branchTaken,
   output logic                    stall,
   output logic                    flush
);

   opcodeT                  opcode;
   logic [regAddrWidth-1:0] rs;
   logic [regAddrWidth-1:0] rt;
   logic                    usesRt;
   logic                    exHitsRs;
   logic                    exHitsRt;
   logic                    memHits;
   logic                    loadUse;
   logic                    branchWait;

   assign opcode = opcodeT'(idInstruction[opcodeMsb:opcodeLsb]);
   assign rs     = idInstruction[rsMsb:rsLsb];
   assign rt     = idInstruction[rtMsb:rtLsb];
   assign usesRt = (opcode != lw);   // lw writes rt, does not read it

   assign exHitsRs = (exDest != '0) && (exDest == rs);
   assign exHitsRt = (exDest != '0) && (exDest == rt);
   assign memHits  = (memDest != '0) && ((memDest == rs) || (memDest == rt));

   // --------------------------------------------------
   // stall sources
   assign loadUse    = exMemRead && (exHitsRs || (usesRt && exHitsRt));
   // beq compares in decode, only a mem-stage ALU result can be forwarded
   assign branchWait = (opcode == beq) &&
                       ((exRegWrite && (exHitsRs || exHitsRt)) || (memMemRead && memHits));

   assign stall = loadUse || branchWait;
   assign flush = branchTaken;

   // decode must hold off a branch it is still waiting on
   noStallWithFlush: assert final (!(stall && flush));

endmodule

/* logic/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage import isaPkg::*, pipelinePkg::*;
(
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 stall,
   input  logic                 flush,
   input  logic                 branchTaken,
   input  logic [dataWidth-1:0] branchTarget,
   input  logic [dataWidth-1:0] instruction,
   output logic [dataWidth-1:0] fetchAddress,
   output logic [dataWidth-1:0] idInstruction,
   output logic [dataWidth-1:0] idPcPlus4
);

   logic [dataWidth-1:0] pc;
   logic [dataWidth-1:0] pcPlus4;
   logic [dataWidth-1:0] nextPc;

   assign pcPlus4      = pc + dataWidth'(4);
   assign nextPc       = branchTaken ? branchTarget : pcPlus4;   // beq resolved in decode
   assign fetchAddress = pc;

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         pc            <= resetPc;
         idInstruction <= nopWord;
      end
      else if (flush)
      begin
         pc            <= nextPc;
         idInstruction <= nopWord;   // squash the fall-through word
      end
      else if (!stall)
      begin
         pc            <= nextPc;
         idInstruction <= instruction;
      end
   end

   always_ff @(posedge clock)
   begin
      if (!stall)
         idPcPlus4 <= pcPlus4;
   end

   // branch targets come from decode, so check the whole loop
   pcAligned: assert property (@(posedge clock) disable iff (reset)
      fetchAddress[1:0] == 2'b00);

endmodule

/* logic/pipelinePkg.sv */
package pipelinePkg;

   localparam int          dataDepth     = 64;   // data memory words
   localparam int          dataAddrWidth = 6;
   localparam logic [31:0] resetPc       = 32'h0000_0000;

   typedef enum logic [2:0]
   {
      aluAdd = 3'b000,
      aluSub = 3'b001,
      aluAnd = 3'b010,
      aluOr  = 3'b011,
      aluSll = 3'b100
   } aluOpT;

   // what the ALU is used for, refined by funct in execute
   typedef enum logic [1:0]
   {
      memAccess = 2'b00,
      branchCmp = 2'b01,
      rTypeFn   = 2'b10
   } aluClassT;

   typedef enum logic [1:0]
   {
      fromRegister  = 2'b00,
      fromWriteBack = 2'b01,
      fromMemory    = 2'b10
   } forwardT;

endpackage

/* logic/isaPkg.sv */
package isaPkg;

   localparam int dataWidth    = 32;   // word width
   localparam int regAddrWidth = 5;    // 32 registers

   // --------------------------------------------------
   // instruction field positions
   localparam int opcodeMsb = 31;
   localparam int opcodeLsb = 26;
   localparam int rsMsb     = 25;
   localparam int rsLsb     = 21;
   localparam int rtMsb     = 20;
   localparam int rtLsb     = 16;
   localparam int rdMsb     = 15;
   localparam int rdLsb     = 11;
   localparam int shamtMsb  = 10;
   localparam int shamtLsb  = 6;
   localparam int functMsb  = 5;
   localparam int functLsb  = 0;
   localparam int immMsb    = 15;
   localparam int immLsb    = 0;

   localparam logic [dataWidth-1:0] nopWord = '0;   // sll $0, $0, 0

   typedef enum logic [5:0]
   {
      rType = 6'b000000,
      lw    = 6'b100011,
      sw    = 6'b101011,
      beq   = 6'b000100
   } opcodeT;

   // R-type function field
   typedef enum logic [5:0]
   {
      sllF = 6'b000000,
      addF = 6'b100000,
      subF = 6'b100010,
      andF = 6'b100100,
      orF  = 6'b100101
   } functT;

endpackage
